//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module cmd_hub_tb -Mdir obj_dir -o sim_cmd_hub
	./obj_dir/sim_cmd_hub > sim.log 2>&1
	cat sim.log
	! grep -q "Simulation FAILED" sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cmd_hub/cmd_arbiter.sv
/*
 * Cluster command arbiter
 * Round-robin choice among the cluster command requests, forwarded to
 * the command slot on a single valid/ready pair.
 */
module cmd_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [pspin_cmd_pkg::NUM_CLUSTERS-1:0]                 cmd_valid_i,
  input  pspin_cmd_pkg::pspin_cmd_t [pspin_cmd_pkg::NUM_CLUSTERS-1:0] cmd_i,
  output logic [pspin_cmd_pkg::NUM_CLUSTERS-1:0]                 cmd_ready_o,
  output logic                                                   sel_valid_o,
  output pspin_cmd_pkg::pspin_cmd_t                              sel_cmd_o,
  input  logic                                                   sel_ready_i
);

  import pspin_cmd_pkg::*;

  // Cluster that is looked at first
  logic [CLUSTER_ID_W-1:0] rr_q;
  logic [CLUSTER_ID_W-1:0] grant_idx;

  // Walk from the far end back so the nearest requester at or after rr_q wins
  always_comb begin
    grant_idx = rr_q;
    for (int k = NUM_CLUSTERS - 1; k >= 0; k--) begin
      if (cmd_valid_i[CLUSTER_ID_W'(rr_q + k)]) begin
        grant_idx = CLUSTER_ID_W'(rr_q + k);
      end
    end
  end

  assign sel_valid_o = |cmd_valid_i;
  assign sel_cmd_o   = cmd_i[grant_idx];

  // Only the granted cluster sees ready
  always_comb begin
    cmd_ready_o            = '0;
    cmd_ready_o[grant_idx] = sel_ready_i;
  end

  // Next search starts just past the cluster that was served
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (sel_valid_o && sel_ready_i) begin
      rr_q <= grant_idx + 1'b1;
    end
  end

endmodule

//--- cmd_hub/cmd_hub.sv
/*
 * Cluster command hub
 * Arbitrates cluster commands into one slot, routes them to the eDMA,
 * NIC and host-direct interfaces and broadcasts the merged responses.
 */
module cmd_hub (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic [pspin_cmd_pkg::NUM_CLUSTERS-1:0]                      cmd_valid_i,
  output logic [pspin_cmd_pkg::NUM_CLUSTERS-1:0]                      cmd_ready_o,
  input  pspin_cmd_pkg::pspin_cmd_t [pspin_cmd_pkg::NUM_CLUSTERS-1:0] cmd_i,
  output logic [pspin_cmd_pkg::NUM_CMD_INTF-1:0]                      intf_valid_o,
  input  logic [pspin_cmd_pkg::NUM_CMD_INTF-1:0]                      intf_ready_i,
  output pspin_cmd_pkg::pspin_cmd_t                                   intf_cmd_o,
  input  logic [pspin_cmd_pkg::NUM_CMD_INTF-1:0]                      intf_resp_valid_i,
  input  pspin_cmd_pkg::pspin_cmd_resp_t [pspin_cmd_pkg::NUM_CMD_INTF-1:0] intf_resp_i,
  output logic                                                        cmd_resp_valid_o,
  output pspin_cmd_pkg::pspin_cmd_resp_t                              cmd_resp_o
);

  import pspin_cmd_pkg::*;

  // Arbiter to router
  logic            sel_valid;
  logic            sel_ready;
  pspin_cmd_t      sel_cmd;

  // Router to merge
  logic            err_valid;
  pspin_cmd_resp_t err_resp;

  cmd_arbiter u_cmd_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_ready_o (cmd_ready_o),
    .sel_valid_o (sel_valid),
    .sel_cmd_o   (sel_cmd),
    .sel_ready_i (sel_ready)
  );

  cmd_router u_cmd_router (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (sel_valid),
    .cmd_ready_o  (sel_ready),
    .cmd_i        (sel_cmd),
    .intf_valid_o (intf_valid_o),
    .intf_ready_i (intf_ready_i),
    .intf_cmd_o   (intf_cmd_o),
    .err_valid_o  (err_valid),
    .err_resp_o   (err_resp)
  );

  cmd_resp_merge u_cmd_resp_merge (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .intf_resp_valid_i (intf_resp_valid_i),
    .intf_resp_i       (intf_resp_i),
    .err_valid_i       (err_valid),
    .err_resp_i        (err_resp),
    .resp_valid_o      (cmd_resp_valid_o),
    .resp_o            (cmd_resp_o)
  );

endmodule

//--- cmd_hub/cmd_resp_merge.sv
/*
 * Response merge
 * Buffers one response per source and sends them out one per cycle,
 * error first, then eDMA, NIC and host-direct.
 */
module cmd_resp_merge (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic [pspin_cmd_pkg::NUM_CMD_INTF-1:0]                      intf_resp_valid_i,
  input  pspin_cmd_pkg::pspin_cmd_resp_t [pspin_cmd_pkg::NUM_CMD_INTF-1:0] intf_resp_i,
  input  logic                                                        err_valid_i,
  input  pspin_cmd_pkg::pspin_cmd_resp_t                              err_resp_i,
  output logic                                                        resp_valid_o,
  output pspin_cmd_pkg::pspin_cmd_resp_t                              resp_o
);

  import pspin_cmd_pkg::*;

  // Sources 0 to NUM_CMD_INTF-1 are the interfaces, the top one is the error
  logic            [NUM_CMD_INTF:0] src_valid;
  pspin_cmd_resp_t [NUM_CMD_INTF:0] src_resp;
  logic            [NUM_CMD_INTF:0] buf_valid;
  logic            [NUM_CMD_INTF:0] buf_grant;
  pspin_cmd_resp_t [NUM_CMD_INTF:0] buf_resp;

  assign src_valid = {err_valid_i, intf_resp_valid_i};
  assign src_resp  = {err_resp_i, intf_resp_i};

  // Interfaces space their responses, so a buffer has drained before the
  // next one from the same source arrives
  for (genvar i = 0; i <= NUM_CMD_INTF; i++) begin : gen_buf
    stream_reg #(
      .payload_t (pspin_cmd_resp_t)
    ) u_buf (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .valid_i (src_valid[i]),
      .ready_o (),
      .data_i  (src_resp[i]),
      .valid_o (buf_valid[i]),
      .ready_i (buf_grant[i]),
      .data_o  (buf_resp[i])
    );
  end

  // Highest index wins, which matches error, eDMA, NIC, host-direct
  always_comb begin
    buf_grant = '0;
    resp_o    = buf_resp[0];
    for (int i = 0; i <= NUM_CMD_INTF; i++) begin
      if (buf_valid[i]) begin
        buf_grant    = '0;
        buf_grant[i] = 1'b1;
        resp_o       = buf_resp[i];
      end
    end
  end

  // One drained buffer per cycle gives one pulse per response
  assign resp_valid_o = |buf_valid;

endmodule

//--- cmd_hub/cmd_router.sv
/*
 * Command router
 * Holds the granted command in a one-entry slot and steers it to the
 * interface its code names. Reserved codes complete with an error.
 */
module cmd_router (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      cmd_valid_i,
  output logic                                      cmd_ready_o,
  input  pspin_cmd_pkg::pspin_cmd_t                 cmd_i,
  output logic [pspin_cmd_pkg::NUM_CMD_INTF-1:0]    intf_valid_o,
  input  logic [pspin_cmd_pkg::NUM_CMD_INTF-1:0]    intf_ready_i,
  output pspin_cmd_pkg::pspin_cmd_t                 intf_cmd_o,
  output logic                                      err_valid_o,
  output pspin_cmd_pkg::pspin_cmd_resp_t            err_resp_o
);

  import pspin_cmd_pkg::*;

  logic                    slot_valid;
  logic                    slot_ready;
  pspin_cmd_t              slot_cmd;
  logic [NUM_CMD_INTF-1:0] sel_oh;
  logic                    is_rsvd;

  stream_reg #(
    .payload_t (pspin_cmd_t)
  ) u_slot (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (cmd_valid_i),
    .ready_o (cmd_ready_o),
    .data_i  (cmd_i),
    .valid_o (slot_valid),
    .ready_i (slot_ready),
    .data_o  (slot_cmd)
  );

  // Decode of the held interface code
  assign sel_oh[INTF_HDIR] = (slot_cmd.intf_sel == INTF_HDIR);
  assign sel_oh[INTF_NIC]  = (slot_cmd.intf_sel == INTF_NIC);
  assign sel_oh[INTF_EDMA] = (slot_cmd.intf_sel == INTF_EDMA);
  assign is_rsvd           = (slot_cmd.intf_sel == INTF_RSVD);

  assign intf_valid_o = {NUM_CMD_INTF{slot_valid}} & sel_oh;
  // One payload bus for all interfaces, qualified by their own valid
  assign intf_cmd_o   = slot_cmd;

  // A stalled interface blocks the slot and so every cluster behind it
  assign slot_ready = is_rsvd | (|(sel_oh & intf_ready_i));

  // Reserved code leaves the slot at once as an error completion
  assign err_valid_o       = slot_valid & is_rsvd;
  assign err_resp_o.cmd_id = slot_cmd.cmd_id;
  assign err_resp_o.error  = 1'b1;

endmodule

//--- common/pspin_cmd_pkg.sv
/*
 * Command hub package
 * Sizes, interface codes and the command and response structs shared
 * between the cluster command path and the off-cluster interfaces.
 */
package pspin_cmd_pkg;

  // Command sources and sinks
  localparam int unsigned NUM_CLUSTERS = 4;
  localparam int unsigned NUM_CMD_INTF = 3;

  // Field widths
  localparam int unsigned CLUSTER_ID_W   = 2;
  localparam int unsigned CMD_LOCAL_ID_W = 4;
  localparam int unsigned CMD_DATA_W     = 64;
  localparam int unsigned INTF_SEL_W     = 2;

  // Interface codes, also the bit index of each interface valid
  localparam logic [INTF_SEL_W-1:0] INTF_HDIR = 2'd0;
  localparam logic [INTF_SEL_W-1:0] INTF_NIC  = 2'd1;
  localparam logic [INTF_SEL_W-1:0] INTF_EDMA = 2'd2;
  // No interface behind this code, answered with an error
  localparam logic [INTF_SEL_W-1:0] INTF_RSVD = 2'd3;

  // Cluster number plus the tag the cluster picked for the command
  typedef struct packed {
    logic [CLUSTER_ID_W-1:0]   cluster_id;
    logic [CMD_LOCAL_ID_W-1:0] local_id;
  } pspin_cmd_id_t;

  // Command as raised by a cluster
  typedef struct packed {
    logic [INTF_SEL_W-1:0] intf_sel;
    pspin_cmd_id_t         cmd_id;
    logic [CMD_DATA_W-1:0] data;
  } pspin_cmd_t;

  // Completion, seen by every cluster
  typedef struct packed {
    pspin_cmd_id_t cmd_id;
    logic          error;
  } pspin_cmd_resp_t;

endpackage

//--- logic/stream_reg.sv
/*
 * One-entry valid/ready holding register
 * Accepts when empty or when the held entry leaves in the same cycle.
 */
module stream_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  assign ready_o = ~valid_q | ready_i;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

endmodule

//--- verif/cmd_hub_chk.sv
/*
 * Command hub assertions
 * Handshake stability on the interface side, one interface valid at a
 * time, and no write into a full response buffer of the merge.
 */
module cmd_hub_chk (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input logic [pspin_cmd_pkg::NUM_CMD_INTF-1:0] intf_valid_i,
  input logic [pspin_cmd_pkg::NUM_CMD_INTF-1:0] intf_ready_i,
  input pspin_cmd_pkg::pspin_cmd_t              intf_cmd_i,
  input logic [pspin_cmd_pkg::NUM_CMD_INTF:0]   buf_valid_i,
  input logic [pspin_cmd_pkg::NUM_CMD_INTF:0]   buf_grant_i,
  input logic [pspin_cmd_pkg::NUM_CMD_INTF:0]   buf_write_i
);

  import pspin_cmd_pkg::*;

  // Stalled command keeps its valid and payload
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|(intf_valid_i & ~intf_ready_i)) |=>
      (intf_valid_i == $past(intf_valid_i)) && $stable(intf_cmd_i))
    else $error("interface command changed while stalled");

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(intf_valid_i))
    else $error("more than one interface valid high");

  // A held response that is not leaving must not be overwritten
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (buf_write_i & buf_valid_i & ~buf_grant_i) == '0)
    else $error("response buffer written while full");

endmodule

//--- verif/cmd_hub_tb.sv
/*
 * Command hub testbench
 * Directed tests for routing, round-robin order, back-pressure,
 * response merge priority and reserved-code errors.
 */
module cmd_hub_tb;

  import pspin_cmd_pkg::*;

  localparam int TIMEOUT = 50;

  logic                                     clk;
  logic                                     rst_n;
  logic            [NUM_CLUSTERS-1:0]       cmd_valid;
  logic            [NUM_CLUSTERS-1:0]       cmd_ready;
  pspin_cmd_t      [NUM_CLUSTERS-1:0]       cmd_in;
  logic            [NUM_CMD_INTF-1:0]       intf_valid;
  logic            [NUM_CMD_INTF-1:0]       intf_ready;
  pspin_cmd_t                               intf_cmd;
  logic            [NUM_CMD_INTF-1:0]       resp_valid_in;
  pspin_cmd_resp_t [NUM_CMD_INTF-1:0]       resp_in;
  logic                                     resp_valid;
  pspin_cmd_resp_t                          resp;

  int errors = 0;
  int checks = 0;
  int tests  = 0;
  // Model of the round-robin pointer
  int rr     = 0;

  tb_clk_gen u_tb_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  cmd_hub u_cmd_hub (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .cmd_valid_i       (cmd_valid),
    .cmd_ready_o       (cmd_ready),
    .cmd_i             (cmd_in),
    .intf_valid_o      (intf_valid),
    .intf_ready_i      (intf_ready),
    .intf_cmd_o        (intf_cmd),
    .intf_resp_valid_i (resp_valid_in),
    .intf_resp_i       (resp_in),
    .cmd_resp_valid_o  (resp_valid),
    .cmd_resp_o        (resp)
  );

  bind cmd_hub cmd_hub_chk u_cmd_hub_chk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .intf_valid_i (intf_valid_o),
    .intf_ready_i (intf_ready_i),
    .intf_cmd_i   (intf_cmd_o),
    .buf_valid_i  (u_cmd_resp_merge.buf_valid),
    .buf_grant_i  (u_cmd_resp_merge.buf_grant),
    .buf_write_i  (u_cmd_resp_merge.src_valid)
  );

  function automatic pspin_cmd_t make_cmd(input int intf, input int cluster);
    pspin_cmd_t c;
    c.intf_sel          = INTF_SEL_W'(intf);
    c.cmd_id.cluster_id = CLUSTER_ID_W'(cluster);
    c.cmd_id.local_id   = CMD_LOCAL_ID_W'($urandom);
    c.data              = {$urandom, $urandom};
    return c;
  endfunction

  // First requester at or after the pointer
  function automatic int next_grant(input logic [NUM_CLUSTERS-1:0] pend, input int ptr);
    int idx;
    for (int k = 0; k < NUM_CLUSTERS; k++) begin
      idx = (ptr + k) % NUM_CLUSTERS;
      if (pend[idx]) return idx;
    end
    return -1;
  endfunction

  task automatic fail(input string msg);
    errors++;
    $display("FAILED at time %0t: %s", $time, msg);
  endtask

  task automatic check_cmd(input pspin_cmd_t exp, input int intf);
    checks++;
    if (intf_valid != NUM_CMD_INTF'(1 << intf)) begin
      fail($sformatf("interface valid %b, expected only interface %0d", intf_valid, intf));
    end else if (intf_cmd != exp) begin
      fail($sformatf("interface command %h, expected %h", intf_cmd, exp));
    end
  endtask

  task automatic check_resp(input pspin_cmd_resp_t exp);
    checks++;
    if (!resp_valid) begin
      fail($sformatf("no response, expected %h", exp));
    end else if (resp != exp) begin
      fail($sformatf("response %h, expected %h", resp, exp));
    end
  endtask

  task automatic check_ready(input logic [NUM_CLUSTERS-1:0] exp);
    checks++;
    if (cmd_ready != exp) begin
      fail($sformatf("cluster ready %b, expected %b", cmd_ready, exp));
    end
  endtask

  task automatic wait_handshake(output int who);
    int t;
    who = -1;
    t   = 0;
    while (who < 0 && t < TIMEOUT) begin
      @(negedge clk);
      for (int c = 0; c < NUM_CLUSTERS; c++) begin
        if (cmd_valid[c] && cmd_ready[c]) who = c;
      end
      t++;
    end
    if (who < 0) begin
      errors++;
      $display("Timeout: no cluster command was accepted within %0d cycles", TIMEOUT);
    end
  endtask

  // Drains the requesting clusters, checking grant order and routing
  task automatic run_batch(input logic [NUM_CLUSTERS-1:0] pend, input int prev);
    int who;
    int exp;
    while (pend != '0) begin
      exp = next_grant(pend, rr);
      wait_handshake(who);
      if (prev >= 0) check_cmd(cmd_in[prev], int'(cmd_in[prev].intf_sel));
      if (who < 0) return;
      if (who != exp) fail($sformatf("cluster %0d granted, expected %0d", who, exp));
      pend[who] = 1'b0;
      rr        = (who + 1) % NUM_CLUSTERS;
      prev      = who;
      @(posedge clk);
      cmd_valid[who] <= 1'b0;
    end
    @(negedge clk);
    check_cmd(cmd_in[prev], int'(cmd_in[prev].intf_sel));
  endtask

  task automatic request_all(input int edma_cluster);
    @(posedge clk);
    for (int c = 0; c < NUM_CLUSTERS; c++) begin
      cmd_in[c]    <= make_cmd(c == edma_cluster ? INTF_EDMA : $urandom_range(0, 1), c);
      cmd_valid[c] <= 1'b1;
    end
  endtask

  task automatic test_single_route();
    for (int i = 0; i < NUM_CMD_INTF; i++) begin
      @(posedge clk);
      cmd_in[i]    <= make_cmd(i, i);
      cmd_valid[i] <= 1'b1;
      run_batch(NUM_CLUSTERS'(1 << i), -1);
    end
    tests++;
    $display("test_single_route done, errors %0d", errors);
  endtask

  task automatic test_round_robin();
    request_all(-1);
    run_batch('1, -1);
    request_all(-1);
    run_batch('1, -1);
    tests++;
    $display("test_round_robin done, errors %0d", errors);
  endtask

  task automatic test_backpressure();
    int first;
    int who;
    first = rr;
    @(posedge clk);
    intf_ready[INTF_EDMA] <= 1'b0;
    request_all(first);
    wait_handshake(who);
    if (who != first) fail($sformatf("cluster %0d granted, expected %0d", who, first));
    rr = (first + 1) % NUM_CLUSTERS;
    @(posedge clk);
    cmd_valid[first] <= 1'b0;
    // Slot blocked by the eDMA, nobody else may enter
    repeat (4) begin
      @(negedge clk);
      check_cmd(cmd_in[first], INTF_EDMA);
      check_ready('0);
    end
    @(posedge clk);
    intf_ready[INTF_EDMA] <= 1'b1;
    run_batch(~(NUM_CLUSTERS'(1 << first)), first);
    tests++;
    $display("test_backpressure done, errors %0d", errors);
  endtask

  task automatic test_resp_merge();
    pspin_cmd_resp_t exp [NUM_CMD_INTF];
    for (int i = 0; i < NUM_CMD_INTF; i++) exp[i] = pspin_cmd_resp_t'($urandom);
    @(posedge clk);
    resp_valid_in <= '1;
    for (int i = 0; i < NUM_CMD_INTF; i++) resp_in[i] <= exp[i];
    @(posedge clk);
    resp_valid_in <= '0;
    @(negedge clk);
    check_resp(exp[INTF_EDMA]);
    @(negedge clk);
    check_resp(exp[INTF_NIC]);
    @(negedge clk);
    check_resp(exp[INTF_HDIR]);
    @(negedge clk);
    checks++;
    if (resp_valid) fail("extra response after the merged three");
    tests++;
    $display("test_resp_merge done, errors %0d", errors);
  endtask

  task automatic test_reserved();
    int              who;
    int              c;
    pspin_cmd_resp_t exp;
    c = rr;
    @(posedge clk);
    cmd_in[c]    <= make_cmd(INTF_RSVD, c);
    cmd_valid[c] <= 1'b1;
    wait_handshake(who);
    if (who != c) fail($sformatf("cluster %0d granted, expected %0d", who, c));
    rr = (c + 1) % NUM_CLUSTERS;
    exp.cmd_id = cmd_in[c].cmd_id;
    exp.error  = 1'b1;
    @(posedge clk);
    cmd_valid[c] <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      checks++;
      if (intf_valid != '0) fail($sformatf("interface valid %b for reserved code", intf_valid));
    end
    check_resp(exp);
    tests++;
    $display("test_reserved done, errors %0d", errors);
  endtask

  initial begin
    int t;
    void'($urandom(41747));
    cmd_valid     = '0;
    cmd_in        = '0;
    intf_ready    = '1;
    resp_valid_in = '0;
    resp_in       = '0;
    t = 0;
    while (!rst_n && t < 40) begin
      @(posedge clk);
      t++;
    end
    if (!rst_n) begin
      errors++;
      $display("Timeout: reset was never released");
    end else begin
      test_round_robin();
      test_single_route();
      test_backpressure();
      test_resp_merge();
      test_reserved();
    end
    repeat (4) @(posedge clk);
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- verif/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * 8 unit clock period, reset held low for the first 10 cycles.
 */
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #4 clk_o = ~clk_o;

endmodule

//--- verilog.f
common/pspin_cmd_pkg.sv
logic/stream_reg.sv
cmd_hub/cmd_arbiter.sv
cmd_hub/cmd_router.sv
cmd_hub/cmd_resp_merge.sv
cmd_hub/cmd_hub.sv
verif/tb_clk_gen.sv
verif/cmd_hub_chk.sv
verif/cmd_hub_tb.sv
